// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f files.f --top-module mmu_tb -o mmu_sim
	./obj_dir/mmu_sim | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: files.f
+incdir+logic
logic/mmu_pkg.sv
logic/dcache_if.sv
logic/dtlb.sv
logic/ptw.sv
logic/dcache.sv
logic/mmu_vm_top.sv
verification/mmu_tb.sv

// File: logic/dcache.sv
// Data cache: direct-mapped, write-through, no write-allocate, single-word fill
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

module dcache (
  input  wire                      clk_i,
  input  wire                      rst_n_i,

  dcache_if.cache                  cache,
  input  wire                      poison_i,

  output logic                     mem_rd_v_o,
  output logic                     mem_wr_v_o,
  output logic [`MMU_PADDR_W-1:0]  mem_addr_o,
  output logic [`MMU_DATA_W-1:0]   mem_wdata_o,
  input  wire [`MMU_DATA_W-1:0]    mem_rdata_i,
  input  wire                      mem_rdata_v_i
);

  localparam int IDX_W  = $clog2(`MMU_DCACHE_SETS);
  localparam int BYTE_W = `MMU_PAGE_OFFSET_W - IDX_W;

  // Storage
  logic [`MMU_DCACHE_SETS-1:0] valid_r;
  logic [`MMU_PTAG_W-1:0]      tag_mem  [`MMU_DCACHE_SETS];
  logic [`MMU_DATA_W-1:0]      data_mem [`MMU_DCACHE_SETS];

  // Second-stage request
  logic                   req_v_r;
  mmu_pkg::dcache_pkt_s   pkt_r;
  logic [`MMU_PTAG_W-1:0] ptag_r;
  logic                   fill_busy_r;

  logic                   take;
  logic [IDX_W-1:0]       idx;
  logic                   hit;
  logic                   is_store;
  logic                   load_miss;
  logic                   store_ok;
  logic                   fill_done;

  assign take = cache.pkt_v & cache.ready;

  assign idx       = pkt_r.page_offset[`MMU_PAGE_OFFSET_W-1:BYTE_W];
  assign hit       = valid_r[idx] && (tag_mem[idx] == ptag_r);
  assign is_store  = (pkt_r.op == mmu_pkg::MEM_STORE);
  assign load_miss = req_v_r & ~is_store & ~hit & ~poison_i;
  assign store_ok  = req_v_r & is_store & ~poison_i;
  assign fill_done = fill_busy_r & mem_rdata_v_i;

  // Closed from the miss cycle until the fill word is written
  assign cache.ready = ~fill_busy_r & ~load_miss;

  // Stores always answer, loads only on a hit
  assign cache.v    = req_v_r & ~poison_i & (is_store | hit);
  assign cache.miss = load_miss;
  assign cache.data = data_mem[idx];

  // Fill request and write-through share the word address
  assign mem_rd_v_o  = load_miss;
  assign mem_wr_v_o  = store_ok;
  assign mem_addr_o  = {ptag_r, idx, {BYTE_W{1'b0}}};
  assign mem_wdata_o = pkt_r.data;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_v_r     <= 1'b0;
      fill_busy_r <= 1'b0;
      valid_r     <= '0;
    end else begin
      // Packets without a translation get no response
      req_v_r <= take & ~cache.tlb_miss;
      if (load_miss) begin
        fill_busy_r <= 1'b1;
      end else if (fill_done) begin
        fill_busy_r <= 1'b0;
      end
      if (fill_done) begin
        valid_r[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      pkt_r  <= cache.pkt;
      ptag_r <= cache.ptag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_done) begin
      tag_mem[idx]  <= ptag_r;
      data_mem[idx] <= mem_rdata_i;
    end else if (store_ok && hit) begin
      data_mem[idx] <= pkt_r.data;
    end
  end

endmodule

`default_nettype wire

// File: logic/dcache_if.sv
// Cache port bundle: request packet with physical tag, single-cycle response
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

interface dcache_if;

  // Request
  logic                   pkt_v;
  mmu_pkg::dcache_pkt_s   pkt;
  logic [`MMU_PTAG_W-1:0] ptag;
  logic                   tlb_miss;

  // Response, the cycle after a packet is taken
  logic                   ready;
  logic                   v;
  logic [`MMU_DATA_W-1:0] data;
  logic                   miss;

  modport requester (
    output pkt_v, pkt, ptag, tlb_miss,
    input  ready, v, data, miss
  );

  modport cache (
    input  pkt_v, pkt, ptag, tlb_miss,
    output ready, v, data, miss
  );

endinterface

`default_nettype wire

// File: logic/dtlb.sv
// Data TLB: fully associative lookup with round-robin refill
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

module dtlb (
  input  wire                      clk_i,
  input  wire                      rst_n_i,

  input  wire                      r_v_i,
  input  wire [`MMU_VTAG_W-1:0]    r_vtag_i,
  output mmu_pkg::tlb_entry_s      r_entry_o,

  output logic                     miss_v_o,
  output logic [`MMU_VTAG_W-1:0]   miss_vtag_o,

  input  wire                      w_v_i,
  input  wire [`MMU_VTAG_W-1:0]    w_vtag_i,
  input  wire mmu_pkg::tlb_entry_s w_entry_i
);

  localparam int IDX_W = $clog2(`MMU_TLB_ELS);

  logic [`MMU_TLB_ELS-1:0] valid_r;
  logic [`MMU_VTAG_W-1:0]  vtag_mem  [`MMU_TLB_ELS];
  mmu_pkg::tlb_entry_s     entry_mem [`MMU_TLB_ELS];
  logic [IDX_W-1:0]        victim_r;
  logic                    hit;

  // Parallel compare over all valid entries
  always_comb begin
    hit       = 1'b0;
    r_entry_o = '0;
    for (int i = 0; i < `MMU_TLB_ELS; i++) begin
      if (valid_r[i] && (vtag_mem[i] == r_vtag_i)) begin
        hit       = 1'b1;
        r_entry_o = entry_mem[i];
      end
    end
  end

  assign miss_v_o = r_v_i & ~hit;

  // Missing tag held for the walker
  always_ff @(posedge clk_i) begin
    if (miss_v_o) begin
      miss_vtag_o <= r_vtag_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_r  <= '0;
      victim_r <= '0;
    end else if (w_v_i) begin
      valid_r[victim_r] <= 1'b1;
      victim_r          <= victim_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_v_i) begin
      vtag_mem[victim_r]  <= w_vtag_i;
      entry_mem[victim_r] <= w_entry_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/mmu_defines.svh
// MMU geometry: address, data, TLB and page table widths and sizes
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// Address and data widths
`define MMU_VADDR_W 20
`define MMU_PADDR_W 16
`define MMU_DATA_W 32

// 256-byte pages
`define MMU_PAGE_OFFSET_W 8

// Page tags, derived
`define MMU_VTAG_W (`MMU_VADDR_W - `MMU_PAGE_OFFSET_W)
`define MMU_PTAG_W (`MMU_PADDR_W - `MMU_PAGE_OFFSET_W)

// Two-level page table, six index bits per level
`define MMU_PT_INDEX_W 6

// Translation buffer entries
`define MMU_TLB_ELS 8

// Cache sets, one word per set
`define MMU_DCACHE_SETS 64

`endif

// File: logic/mmu_pkg.sv
// MMU package: operation, TLB entry, cache packet, PTE and walker state types
`default_nettype none

`include "mmu_defines.svh"

package mmu_pkg;

  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

  typedef struct packed {
    logic [`MMU_PTAG_W-1:0] ptag;
  } tlb_entry_s;

  // Cache access, untranslated part of the address only
  typedef struct packed {
    mem_op_e                       op;
    logic [`MMU_PAGE_OFFSET_W-1:0] page_offset;
    logic [`MMU_DATA_W-1:0]        data;
  } dcache_pkt_s;

  // Page table entry as read from memory
  typedef struct packed {
    logic [`MMU_DATA_W-`MMU_PTAG_W-9:0] rsvd_hi;
    logic [`MMU_PTAG_W-1:0]             ppn;
    logic [5:0]                         rsvd_lo;
    logic                               leaf;
    logic                               valid;
  } pte_s;

  typedef enum logic [2:0] {
    PTW_IDLE,
    PTW_L1_REQ,
    PTW_L1_WAIT,
    PTW_L0_REQ,
    PTW_L0_WAIT,
    PTW_WRITE
  } ptw_state_e;

endpackage

`default_nettype wire

// File: logic/mmu_vm_top.sv
// MMU top: TLB lookup, walker and cache steering, core command and response
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

module mmu_vm_top (
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire [`MMU_PTAG_W-1:0]   satp_ppn_i,

  input  wire                     mmu_cmd_v_i,
  input  wire mmu_pkg::mem_op_e   mmu_cmd_op_i,
  input  wire [`MMU_VADDR_W-1:0]  mmu_cmd_vaddr_i,
  input  wire [`MMU_DATA_W-1:0]   mmu_cmd_data_i,
  output logic                    mmu_cmd_ready_o,

  input  wire                     chk_poison_i,

  output logic                    mmu_resp_v_o,
  output logic [`MMU_DATA_W-1:0]  mmu_resp_data_o,
  output logic                    mmu_resp_tlb_miss_o,
  output logic                    mmu_resp_cache_miss_o,

  output logic                    mem_rd_v_o,
  output logic                    mem_wr_v_o,
  output logic [`MMU_PADDR_W-1:0] mem_addr_o,
  output logic [`MMU_DATA_W-1:0]  mem_wdata_o,
  input  wire [`MMU_DATA_W-1:0]   mem_rdata_i,
  input  wire                     mem_rdata_v_i
);

  logic [`MMU_VTAG_W-1:0]        vtag;
  logic [`MMU_PAGE_OFFSET_W-1:0] page_offset;

  logic                   tlb_miss, tlb_miss_r, tlb_w_v;
  logic [`MMU_VTAG_W-1:0] tlb_miss_vtag, tlb_w_vtag;
  mmu_pkg::tlb_entry_s    tlb_r_entry, tlb_w_entry;

  logic                   ptw_busy, ptw_pkt_v;
  mmu_pkg::dcache_pkt_s   ptw_pkt, core_pkt;
  logic [`MMU_PTAG_W-1:0] ptw_ptag;

  logic                   ready_en_r;
  logic                   cmd_fire;

  dcache_if dc_if ();

  assign {vtag, page_offset} = mmu_cmd_vaddr_i;

  assign mmu_cmd_ready_o = ready_en_r & dc_if.ready & ~tlb_miss_r & ~ptw_busy;
  assign cmd_fire        = mmu_cmd_v_i & mmu_cmd_ready_o;

  dtlb u_dtlb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .r_v_i       (cmd_fire),
    .r_vtag_i    (vtag),
    .r_entry_o   (tlb_r_entry),
    .miss_v_o    (tlb_miss),
    .miss_vtag_o (tlb_miss_vtag),
    .w_v_i       (tlb_w_v),
    .w_vtag_i    (tlb_w_vtag),
    .w_entry_i   (tlb_w_entry)
  );

  ptw u_ptw (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .base_ppn_i      (satp_ppn_i),
    .tlb_miss_v_i    (tlb_miss_r),
    .tlb_miss_vtag_i (tlb_miss_vtag),
    .busy_o          (ptw_busy),
    .tlb_w_v_o       (tlb_w_v),
    .tlb_w_vtag_o    (tlb_w_vtag),
    .tlb_w_entry_o   (tlb_w_entry),
    .dcache_v_o      (ptw_pkt_v),
    .dcache_pkt_o    (ptw_pkt),
    .dcache_ptag_o   (ptw_ptag),
    .dcache_ready_i  (dc_if.ready),
    .dcache_v_i      (dc_if.v),
    .dcache_miss_i   (dc_if.miss),
    .dcache_data_i   (dc_if.data)
  );

  dcache u_dcache (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cache         (dc_if.cache),
    .poison_i      (chk_poison_i & ~ptw_busy),
    .mem_rd_v_o    (mem_rd_v_o),
    .mem_wr_v_o    (mem_wr_v_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rdata_v_i (mem_rdata_v_i)
  );

  // Walker owns the cache while busy
  always_comb begin
    core_pkt.op          = mmu_cmd_op_i;
    core_pkt.page_offset = page_offset;
    core_pkt.data        = mmu_cmd_data_i;

    dc_if.pkt_v    = ptw_busy ? ptw_pkt_v : cmd_fire;
    dc_if.pkt      = ptw_busy ? ptw_pkt : core_pkt;
    dc_if.ptag     = ptw_busy ? ptw_ptag : tlb_r_entry.ptag;
    dc_if.tlb_miss = ptw_busy ? 1'b0 : tlb_miss;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tlb_miss_r <= 1'b0;
      ready_en_r <= 1'b0;
    end else begin
      tlb_miss_r <= cmd_fire & tlb_miss;
      ready_en_r <= 1'b1;
    end
  end

  // Walker traffic never reaches the core
  assign mmu_resp_v_o = ~ptw_busy & (dc_if.v | dc_if.miss | (tlb_miss_r & ~chk_poison_i));
  assign mmu_resp_data_o       = dc_if.data;
  assign mmu_resp_tlb_miss_o   = tlb_miss_r;
  assign mmu_resp_cache_miss_o = dc_if.miss;

endmodule

`default_nettype wire

// File: logic/ptw.sv
// Page table walker: two-level walk through the data cache, refills the TLB
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

module ptw (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire [`MMU_PTAG_W-1:0]     base_ppn_i,

  input  wire                       tlb_miss_v_i,
  input  wire [`MMU_VTAG_W-1:0]     tlb_miss_vtag_i,
  output logic                      busy_o,

  output logic                      tlb_w_v_o,
  output logic [`MMU_VTAG_W-1:0]    tlb_w_vtag_o,
  output mmu_pkg::tlb_entry_s       tlb_w_entry_o,

  output logic                      dcache_v_o,
  output mmu_pkg::dcache_pkt_s      dcache_pkt_o,
  output logic [`MMU_PTAG_W-1:0]    dcache_ptag_o,
  input  wire                       dcache_ready_i,
  input  wire                       dcache_v_i,
  input  wire                       dcache_miss_i,
  input  wire [`MMU_DATA_W-1:0]     dcache_data_i
);

  localparam int PTE_BYTE_W = `MMU_PAGE_OFFSET_W - `MMU_PT_INDEX_W;

  mmu_pkg::ptw_state_e         state_r, state_n;
  logic [`MMU_VTAG_W-1:0]      vtag_r;
  logic [`MMU_PTAG_W-1:0]      ppn_r, ppn_n;
  logic                        in_l1;
  logic [`MMU_PT_INDEX_W-1:0]  pt_index;
  mmu_pkg::pte_s               pte;

  assign pte   = mmu_pkg::pte_s'(dcache_data_i);
  assign in_l1 = (state_r == mmu_pkg::PTW_L1_REQ) || (state_r == mmu_pkg::PTW_L1_WAIT);

  // Upper tag bits index level one, lower bits level zero
  assign pt_index = in_l1 ? vtag_r[`MMU_VTAG_W-1 -: `MMU_PT_INDEX_W]
                          : vtag_r[`MMU_PT_INDEX_W-1:0];

  always_comb begin
    state_n = state_r;
    ppn_n   = ppn_r;
    unique case (state_r)
      mmu_pkg::PTW_IDLE: begin
        if (tlb_miss_v_i) begin
          state_n = mmu_pkg::PTW_L1_REQ;
          ppn_n   = base_ppn_i;
        end
      end
      mmu_pkg::PTW_L1_REQ, mmu_pkg::PTW_L0_REQ: begin
        if (dcache_ready_i) begin
          state_n = in_l1 ? mmu_pkg::PTW_L1_WAIT : mmu_pkg::PTW_L0_WAIT;
        end
      end
      mmu_pkg::PTW_L1_WAIT, mmu_pkg::PTW_L0_WAIT: begin
        if (dcache_v_i) begin
          if (!pte.valid) begin
            state_n = mmu_pkg::PTW_IDLE;
          end else begin
            ppn_n   = pte.ppn;
            // Leaf at level one is a large mapping, stop early
            state_n = (pte.leaf || !in_l1) ? mmu_pkg::PTW_WRITE : mmu_pkg::PTW_L0_REQ;
          end
        end else if (dcache_miss_i) begin
          // Reissue once the fill is done
          state_n = in_l1 ? mmu_pkg::PTW_L1_REQ : mmu_pkg::PTW_L0_REQ;
        end
      end
      mmu_pkg::PTW_WRITE: state_n = mmu_pkg::PTW_IDLE;
      default: state_n = mmu_pkg::PTW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= mmu_pkg::PTW_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    ppn_r <= ppn_n;
    if ((state_r == mmu_pkg::PTW_IDLE) && tlb_miss_v_i) begin
      vtag_r <= tlb_miss_vtag_i;
    end
  end

  assign busy_o = (state_r != mmu_pkg::PTW_IDLE);

  // PTE loads
  assign dcache_v_o = (state_r == mmu_pkg::PTW_L1_REQ) || (state_r == mmu_pkg::PTW_L0_REQ);
  assign dcache_pkt_o.op          = mmu_pkg::MEM_LOAD;
  assign dcache_pkt_o.page_offset = {pt_index, {PTE_BYTE_W{1'b0}}};
  assign dcache_pkt_o.data        = '0;
  assign dcache_ptag_o            = ppn_r;

  assign tlb_w_v_o          = (state_r == mmu_pkg::PTW_WRITE);
  assign tlb_w_vtag_o       = vtag_r;
  assign tlb_w_entry_o.ptag = ppn_r;

endmodule

`default_nettype wire

// File: verification/mmu_tb.sv
// MMU testbench with file-driven commands, retry and a random-latency memory model
`timescale 1ns/10ps
`default_nettype none

`include "mmu_defines.svh"

module mmu_tb;

  localparam int MAX_CMDS = 64;

  logic                     clk_i;
  logic                     rst_n_i;
  logic [`MMU_PTAG_W-1:0]   satp_ppn_i;
  logic                     mmu_cmd_v_i;
  mmu_pkg::mem_op_e         mmu_cmd_op_i;
  logic [`MMU_VADDR_W-1:0]  mmu_cmd_vaddr_i;
  logic [`MMU_DATA_W-1:0]   mmu_cmd_data_i;
  logic                     mmu_cmd_ready_o;
  logic                     chk_poison_i;
  logic                     mmu_resp_v_o;
  logic [`MMU_DATA_W-1:0]   mmu_resp_data_o;
  logic                     mmu_resp_tlb_miss_o;
  logic                     mmu_resp_cache_miss_o;
  logic                     mem_rd_v_o;
  logic                     mem_wr_v_o;
  logic [`MMU_PADDR_W-1:0]  mem_addr_o;
  logic [`MMU_DATA_W-1:0]   mem_wdata_o;
  logic [`MMU_DATA_W-1:0]   mem_rdata_i;
  logic                     mem_rdata_v_i;

  // Word-addressed physical memory
  logic [31:0] mem [1 << (`MMU_PADDR_W - 2)];

  // Commands from the tests file
  logic [0:0]  c_op     [MAX_CMDS];
  logic [31:0] c_vaddr  [MAX_CMDS];
  logic [31:0] c_wdata  [MAX_CMDS];
  logic [31:0] c_exp    [MAX_CMDS];
  logic [31:0] c_paddr  [MAX_CMDS];
  logic [0:0]  c_tlb    [MAX_CMDS];
  logic [0:0]  c_cache  [MAX_CMDS];
  logic [0:0]  c_poison [MAX_CMDS];

  int ncmds = 0;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int cycle_limit = 0;
  int seed = 81108;
  int rd_wait = 0;
  logic [`MMU_PADDR_W-1:0] rd_addr = '0;

  mmu_vm_top mmu_vm_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // Memory model answers fetches after 1 to 4 cycles
  always @(posedge clk_i) begin
    mem_rdata_v_i <= 1'b0;
    if (mem_wr_v_o) begin
      mem[mem_addr_o[`MMU_PADDR_W-1:2]] <= mem_wdata_o;
    end
    if (mem_rd_v_o) begin
      rd_addr <= mem_addr_o;
      rd_wait <= 1 + int'($unsigned($random(seed)) % 4);
    end else if (rd_wait == 1) begin
      mem_rdata_v_i <= 1'b1;
      mem_rdata_i   <= mem[rd_addr[`MMU_PADDR_W-1:2]];
      rd_wait       <= 0;
    end else if (rd_wait > 1) begin
      rd_wait <= rd_wait - 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic load_tests();
    int    fd;
    string line;
    logic [31:0] f [8];
    fd = $fopen("verification/mmu_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the tests file");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "P %h %h", f[0], f[1]) == 2) begin
          mem[f[0][`MMU_PADDR_W-1:2]] <= f[1];
        end else if ($sscanf(line, "C %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                             f[3], f[4], f[5], f[6], f[7]) == 8) begin
          c_op[ncmds]     = f[0][0];
          c_vaddr[ncmds]  = f[1];
          c_wdata[ncmds]  = f[2];
          c_exp[ncmds]    = f[3];
          c_paddr[ncmds]  = f[4];
          c_tlb[ncmds]    = f[5][0];
          c_cache[ncmds]  = f[6][0];
          c_poison[ncmds] = f[7][0];
          ncmds++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Issue one command and retry after TLB or cache misses
  task automatic run_cmd(input int k);
    bit first;
    bit done;
    first = 1'b1;
    done  = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      mmu_cmd_v_i     <= 1'b1;
      mmu_cmd_op_i    <= mmu_pkg::mem_op_e'(c_op[k]);
      mmu_cmd_vaddr_i <= c_vaddr[k][`MMU_VADDR_W-1:0];
      mmu_cmd_data_i  <= c_wdata[k];
      do @(negedge clk_i); while (!mmu_cmd_ready_o);
      @(posedge clk_i);
      mmu_cmd_v_i  <= 1'b0;
      chk_poison_i <= c_poison[k];
      @(negedge clk_i);
      if (c_poison[k]) begin
        check_value("mmu_resp_v_o", 32'(mmu_resp_v_o), 32'h0);
        done = 1'b1;
      end else begin
        check_value("mmu_resp_v_o", 32'(mmu_resp_v_o), 32'h1);
        if (!mmu_resp_v_o) begin
          done = 1'b1;
        end else begin
          if (first) begin
            check_value("mmu_resp_tlb_miss_o", 32'(mmu_resp_tlb_miss_o), 32'(c_tlb[k]));
            check_value("mmu_resp_cache_miss_o", 32'(mmu_resp_cache_miss_o),
                        32'(c_cache[k]));
          end
          if (!mmu_resp_tlb_miss_o && !mmu_resp_cache_miss_o) begin
            if (c_op[k] == 1'b0) begin
              check_value("mmu_resp_data_o", mmu_resp_data_o, c_exp[k]);
            end
            done = 1'b1;
          end
        end
      end
      first = 1'b0;
    end
    @(posedge clk_i);
    chk_poison_i <= 1'b0;
    @(negedge clk_i);
    // Response is a single-cycle strobe
    check_value("mmu_resp_v_o", 32'(mmu_resp_v_o), 32'h0);
    // Write-through lands in the memory model
    if (c_op[k] == 1'b1) begin
      check_value("mem", mem[c_paddr[k][`MMU_PADDR_W-1:2]], c_exp[k]);
    end
  endtask

  initial begin
    rst_n_i         = 1'b0;
    satp_ppn_i      = 8'h01;
    mmu_cmd_v_i     = 1'b0;
    mmu_cmd_op_i    = mmu_pkg::MEM_LOAD;
    mmu_cmd_vaddr_i = '0;
    mmu_cmd_data_i  = '0;
    chk_poison_i    = 1'b0;
    mem_rdata_i     = '0;
    mem_rdata_v_i   = 1'b0;
    // Background word is the byte address itself
    for (int i = 0; i < (1 << (`MMU_PADDR_W - 2)); i++) begin
      mem[i] <= {16'ha5a5, i[13:0], 2'b00};
    end
    load_tests();
    assert (ncmds > 0) else begin
      $display("The tests file holds no commands");
      errors++;
    end
    cycle_limit = 200 * ncmds + 20;
    repeat (9) @(posedge clk_i);
    // Outputs stay quiet in reset
    @(negedge clk_i);
    check_value("mmu_cmd_ready_o", 32'(mmu_cmd_ready_o), 32'h0);
    check_value("mmu_resp_v_o", 32'(mmu_resp_v_o), 32'h0);
    check_value("mem_rd_v_o", 32'(mem_rd_v_o), 32'h0);
    check_value("mem_wr_v_o", 32'(mem_wr_v_o), 32'h0);
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    for (int k = 0; k < ncmds; k++) begin
      run_cmd(k);
    end
    $display("Commands %0d, checks %0d, errors %0d", ncmds, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/mmu_tests.txt
# P paddr word : memory preload (page tables)
# C op vaddr wdata expected paddr tlb_miss cache_miss poison (op 0 load, 1 store)
P 0100 00000201
P 0204 00001001
P 0208 00001101
P 020c 00001201
P 0210 00001301
P 0214 00001401
P 0218 00001501
P 021c 00001601
P 0220 00001701
P 0224 00001801
C 0 00180 00000000 a5a51080 1080 1 0 0
C 0 00180 00000000 a5a51080 1080 0 0 0
C 0 00184 00000000 a5a51084 1084 0 1 0
C 1 00188 12345678 12345678 1088 0 0 0
C 0 00188 00000000 12345678 1088 0 1 0
C 1 00180 abcd0001 abcd0001 1080 0 0 0
C 0 00180 00000000 abcd0001 1080 0 0 0
C 0 00280 00000000 a5a51180 1180 1 0 0
C 0 00180 00000000 abcd0001 1080 0 1 0
C 1 00180 deaddead abcd0001 1080 0 0 1
C 0 00180 00000000 abcd0001 1080 0 0 0
C 0 0018c 00000000 00000000 108c 0 0 1
C 0 00340 00000000 a5a51240 1240 1 0 0
C 0 00440 00000000 a5a51340 1340 1 0 0
C 0 00540 00000000 a5a51440 1440 1 0 0
C 0 00640 00000000 a5a51540 1540 1 0 0
C 0 00740 00000000 a5a51640 1640 1 0 0
C 0 00840 00000000 a5a51740 1740 1 0 0
C 0 00940 00000000 a5a51840 1840 1 0 0
C 0 00140 00000000 a5a51040 1040 1 0 0
